//--- verilog/lsu_pkg.sv
// load/store unit shared definitions
`default_nettype none

package lsu_pkg;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 access size codes
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // data window, word addressed ram behind a byte base
  localparam int DMEM_AW = 10;
  localparam int DMEM_WORDS = 2 ** DMEM_AW;
  localparam logic [31:0] DMEM_BASE = 32'h0000_0600;

  // one instruction word, read as i-type for loads and s-type for stores
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
  } rv_mem_instr_u;

endpackage

`default_nettype wire

//--- verilog/lsu_ctrl.sv
// load/store control and address check
`default_nettype none

module lsu_ctrl (
  input  logic                       clkb,
  input  logic                       rstb,
  input  logic                       instr_valid,
  input  logic [31:0]                instr,
  input  logic [31:0]                rs1_val,
  output logic                       stall,
  output logic                       mem_en,
  output logic                       mem_we,
  output logic [lsu_pkg::DMEM_AW-1:0] word_index,
  output logic [1:0]                 byte_off,
  output logic [2:0]                 funct3,
  output logic                       load_valid,
  output logic [4:0]                 load_rd,
  output logic [2:0]                 load_funct3,
  output logic [1:0]                 load_byte_off,
  output logic                       access_fault
);

  lsu_pkg::rv_mem_instr_u ins;
  logic        is_load_op;
  logic        is_store_op;
  logic [31:0] imm_ext;
  logic [31:0] rel_addr;
  logic [2:0]  acc_f3;
  logic        f3_bad;
  logic        misaligned;
  logic        out_of_win;
  logic        fault;
  logic        issue_load;
  logic        issue_store;
  logic        pend_q;

  assign ins = instr;
  assign is_load_op  = (ins.i_fmt.opcode == lsu_pkg::OPC_LOAD);
  assign is_store_op = (ins.s_fmt.opcode == lsu_pkg::OPC_STORE);

  // funct3 sits at the same bits in both views
  assign acc_f3 = ins.i_fmt.funct3;

  // immediate comes from whichever view the opcode selects
  always_comb begin
    if (is_store_op) begin
      imm_ext = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
    end else begin
      imm_ext = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    end
  end

  // offset into the window; anything below the base wraps high
  assign rel_addr   = rs1_val + imm_ext - lsu_pkg::DMEM_BASE;
  assign out_of_win = (rel_addr >= 32'(lsu_pkg::DMEM_WORDS * 4));

  always_comb begin
    case (acc_f3)
      lsu_pkg::F3_B, lsu_pkg::F3_H, lsu_pkg::F3_W: f3_bad = 1'b0;
      lsu_pkg::F3_BU, lsu_pkg::F3_HU:              f3_bad = is_store_op;
      default:                                     f3_bad = 1'b1;
    endcase
    case (acc_f3)
      lsu_pkg::F3_H, lsu_pkg::F3_HU: misaligned = rel_addr[0];
      lsu_pkg::F3_W:                 misaligned = |rel_addr[1:0];
      default:                       misaligned = 1'b0;
    endcase
  end

  assign fault = f3_bad | misaligned | out_of_win;

  // a held load is not reissued in its response cycle
  assign issue_load  = instr_valid & is_load_op & ~pend_q;
  assign issue_store = instr_valid & is_store_op;

  assign stall      = issue_load;
  assign mem_en     = (issue_load | issue_store) & ~fault;
  assign mem_we     = issue_store & ~fault;
  assign word_index = rel_addr[lsu_pkg::DMEM_AW+1:2];
  assign byte_off   = rel_addr[1:0];
  assign funct3     = acc_f3;

  always_ff @(posedge clkb) begin
    if (rstb) begin
      pend_q       <= 1'b0;
      load_valid   <= 1'b0;
      access_fault <= 1'b0;
    end else begin
      pend_q       <= issue_load;
      load_valid   <= issue_load & ~fault;
      access_fault <= (issue_load | issue_store) & fault;
    end
  end

  // response fields for the extract stage
  always_ff @(posedge clkb) begin
    if (issue_load) begin
      load_rd       <= ins.i_fmt.rd;
      load_funct3   <= acc_f3;
      load_byte_off <= rel_addr[1:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/store_align.sv
// store lane placement
`default_nettype none

module store_align (
  input  logic [2:0]  funct3,
  input  logic [1:0]  byte_off,
  input  logic        mem_we,
  input  logic [31:0] rs2_val,
  output logic [3:0]  wr_mask,
  output logic [31:0] wr_data
);

  logic [3:0] lane_mask;

  always_comb begin
    case (funct3)
      lsu_pkg::F3_B: begin
        lane_mask = 4'b0001 << byte_off;
        wr_data   = {24'h0, rs2_val[7:0]} << {byte_off, 3'b000};
      end
      lsu_pkg::F3_H: begin
        // halfword lands in the low or high pair
        lane_mask = byte_off[1] ? 4'b1100 : 4'b0011;
        wr_data   = {16'h0, rs2_val[15:0]} << {byte_off[1], 4'b0000};
      end
      lsu_pkg::F3_W: begin
        lane_mask = 4'b1111;
        wr_data   = rs2_val;
      end
      default: begin
        lane_mask = 4'b0000;
        wr_data   = 32'h0;
      end
    endcase
  end

  // loads and faulty stores write nothing
  assign wr_mask = mem_we ? lane_mask : 4'b0000;

endmodule

`default_nettype wire

//--- verilog/load_extract.sv
// load byte select and extension
`default_nettype none

module load_extract (
  input  logic [31:0] rd_word,
  input  logic [2:0]  load_funct3,
  input  logic [1:0]  load_byte_off,
  output logic [31:0] load_data
);

  logic [31:0] shifted;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // move the addressed lane down to bit 0
  assign shifted  = rd_word >> {load_byte_off, 3'b000};
  assign sel_byte = shifted[7:0];
  assign sel_half = load_byte_off[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    case (load_funct3)
      lsu_pkg::F3_B:  load_data = {{24{sel_byte[7]}}, sel_byte};
      lsu_pkg::F3_H:  load_data = {{16{sel_half[15]}}, sel_half};
      lsu_pkg::F3_BU: load_data = {24'h0, sel_byte};
      lsu_pkg::F3_HU: load_data = {16'h0, sel_half};
      lsu_pkg::F3_W:  load_data = rd_word;
      // illegal sizes never reach here with load_valid set
      default:        load_data = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/data_bram.sv
// byte writable data ram
`default_nettype none

module data_bram (
  input  logic                        clkb,
  input  logic                        mem_en,
  input  logic [lsu_pkg::DMEM_AW-1:0] word_index,
  input  logic [3:0]                  wr_mask,
  input  logic [31:0]                 wr_data,
  output logic [31:0]                 rd_word
);

  logic [31:0] mem_q [lsu_pkg::DMEM_WORDS];
  logic [31:0] merged;

  // contents start cleared
  initial begin
    for (int i = 0; i < lsu_pkg::DMEM_WORDS; i++) begin
      mem_q[i] = 32'h0;
    end
  end

  // write first view of the addressed word
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = wr_mask[b] ? wr_data[8*b +: 8] : mem_q[word_index][8*b +: 8];
    end
  end

  always_ff @(posedge clkb) begin
    if (mem_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_mask[b]) begin
          mem_q[word_index][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
      rd_word <= merged;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
// load/store unit top level
`default_nettype none

module lsu_top (
  input  logic        clkb,
  input  logic        rstb,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic        stall,
  output logic        load_valid,
  output logic [4:0]  load_rd,
  output logic [31:0] load_data,
  output logic        access_fault
);

  logic                        mem_en;
  logic                        mem_we;
  logic [lsu_pkg::DMEM_AW-1:0] word_index;
  logic [1:0]                  byte_off;
  logic [2:0]                  funct3;
  logic [2:0]                  load_funct3;
  logic [1:0]                  load_byte_off;
  logic [3:0]                  wr_mask;
  logic [31:0]                 wr_data;
  logic [31:0]                 rd_word;

  lsu_ctrl ctrl_i (
    .clkb          (clkb),
    .rstb          (rstb),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .rs1_val       (rs1_val),
    .stall         (stall),
    .mem_en        (mem_en),
    .mem_we        (mem_we),
    .word_index    (word_index),
    .byte_off      (byte_off),
    .funct3        (funct3),
    .load_valid    (load_valid),
    .load_rd       (load_rd),
    .load_funct3   (load_funct3),
    .load_byte_off (load_byte_off),
    .access_fault  (access_fault)
  );

  // write side
  store_align store_align_i (
    .funct3   (funct3),
    .byte_off (byte_off),
    .mem_we   (mem_we),
    .rs2_val  (rs2_val),
    .wr_mask  (wr_mask),
    .wr_data  (wr_data)
  );

  data_bram data_bram_i (
    .clkb       (clkb),
    .mem_en     (mem_en),
    .word_index (word_index),
    .wr_mask    (wr_mask),
    .wr_data    (wr_data),
    .rd_word    (rd_word)
  );

  // read side, works on the registered ram word
  load_extract load_extract_i (
    .rd_word       (rd_word),
    .load_funct3   (load_funct3),
    .load_byte_off (load_byte_off),
    .load_data     (load_data)
  );

endmodule

`default_nettype wire

//--- sim/lsu_assertions.sv
// load/store control assertions
`default_nettype none

module lsu_assertions (
  input wire logic        clkb,
  input wire logic        rstb,
  input wire logic [31:0] instr,
  input wire logic [31:0] rs1_val,
  input wire logic        stall,
  input wire logic        mem_we,
  input wire logic        load_valid,
  input wire logic        access_fault
);

  logic [31:0] st_addr;
  logic        st_in_win;
  logic        st_size_ok;

  // store address rebuilt from the raw s-type immediate bits
  assign st_addr   = rs1_val + {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign st_in_win = (st_addr >= lsu_pkg::DMEM_BASE) &&
                     (st_addr < lsu_pkg::DMEM_BASE + 32'(lsu_pkg::DMEM_WORDS * 4));

  always_comb begin
    case (instr[14:12])
      lsu_pkg::F3_B: st_size_ok = 1'b1;
      lsu_pkg::F3_H: st_size_ok = !st_addr[0];
      lsu_pkg::F3_W: st_size_ok = (st_addr[1:0] == 2'b00);
      default:       st_size_ok = 1'b0;
    endcase
  end

  // a response is either data or a fault
  resp_exclusive: assert property (@(posedge clkb) disable iff (rstb)
    !(load_valid && access_fault))
    else $error("load_valid and access_fault high together");

  // a held load stalls for one cycle only
  single_stall: assert property (@(posedge clkb) disable iff (rstb)
    stall |=> (!stall || $changed(instr)))
    else $error("stall held for a second cycle on the same load");

  no_faulty_write: assert property (@(posedge clkb) disable iff (rstb)
    mem_we |-> (st_in_win && st_size_ok))
    else $error("faulty access raised mem_we");

endmodule

bind lsu_ctrl lsu_assertions assertions_i (
  .clkb         (clkb),
  .rstb         (rstb),
  .instr        (instr),
  .rs1_val      (rs1_val),
  .stall        (stall),
  .mem_we       (mem_we),
  .load_valid   (load_valid),
  .access_fault (access_fault)
);

`default_nettype wire

//--- sim/lsu_checker.sv
// load/store response checker
`default_nettype none

module lsu_checker (
  input  wire logic        clkb,
  input  wire logic        rstb,
  input  wire logic        instr_valid,
  input  wire logic [31:0] instr,
  input  wire logic [31:0] rs1_val,
  input  wire logic [31:0] rs2_val,
  input  wire logic        stall,
  input  wire logic        load_valid,
  input  wire logic [4:0]  load_rd,
  input  wire logic [31:0] load_data,
  input  wire logic        access_fault,
  input  string            test_name,
  output int               err_count
);

  logic [7:0] ref_mem [lsu_pkg::DMEM_WORDS*4];
  logic       exp_fault_q;
  // set while a load sits in its stall cycle
  logic       stall_q;

  initial begin
    for (int i = 0; i < lsu_pkg::DMEM_WORDS * 4; i++) begin
      ref_mem[i] = 8'h00;
    end
  end

  function automatic logic [31:0] eff_addr(input logic [31:0] w, input logic [31:0] base_val);
    lsu_pkg::rv_mem_instr_u u;
    logic [11:0] imm;
    u = w;
    if (u.s_fmt.opcode == lsu_pkg::OPC_STORE) begin
      imm = {u.s_fmt.imm_hi, u.s_fmt.imm_lo};
    end else begin
      imm = u.i_fmt.imm;
    end
    return base_val + {{20{imm[11]}}, imm};
  endfunction

  // expected {fault, load value} for one access
  function automatic logic [32:0] ref_access(input logic [31:0] w, input logic [31:0] base_val);
    lsu_pkg::rv_mem_instr_u u;
    logic [31:0] addr;
    logic [11:0] bi;
    logic        is_st;
    logic        bad;
    logic [31:0] val;
    u     = w;
    addr  = eff_addr(w, base_val);
    is_st = (u.s_fmt.opcode == lsu_pkg::OPC_STORE);
    bad   = (addr < lsu_pkg::DMEM_BASE) ||
            (addr >= lsu_pkg::DMEM_BASE + 32'(lsu_pkg::DMEM_WORDS * 4));
    case (u.i_fmt.funct3)
      lsu_pkg::F3_B: ;
      lsu_pkg::F3_H: bad = bad || addr[0];
      lsu_pkg::F3_W: bad = bad || (addr[1:0] != 2'b00);
      lsu_pkg::F3_BU: bad = bad || is_st;
      lsu_pkg::F3_HU: bad = bad || is_st || addr[0];
      default: bad = 1'b1;
    endcase
    val = 32'h0;
    bi  = addr[11:0] - lsu_pkg::DMEM_BASE[11:0];
    if (!bad) begin
      case (u.i_fmt.funct3)
        lsu_pkg::F3_B:  val = {{24{ref_mem[bi][7]}}, ref_mem[bi]};
        lsu_pkg::F3_BU: val = {24'h0, ref_mem[bi]};
        lsu_pkg::F3_H:  val = {{16{ref_mem[bi+1][7]}}, ref_mem[bi+1], ref_mem[bi]};
        lsu_pkg::F3_HU: val = {16'h0, ref_mem[bi+1], ref_mem[bi]};
        default: val = {ref_mem[bi+3], ref_mem[bi+2], ref_mem[bi+1], ref_mem[bi]};
      endcase
    end
    return {bad, val};
  endfunction

  task automatic store_ref(input logic [31:0] w, input logic [31:0] base_val,
                           input logic [31:0] data);
    lsu_pkg::rv_mem_instr_u u;
    logic [31:0] addr;
    logic [11:0] bi;
    int          nbytes;
    u    = w;
    addr = eff_addr(w, base_val);
    bi   = addr[11:0] - lsu_pkg::DMEM_BASE[11:0];
    if (u.s_fmt.funct3 == lsu_pkg::F3_W) begin
      nbytes = 4;
    end else if (u.s_fmt.funct3 == lsu_pkg::F3_H) begin
      nbytes = 2;
    end else begin
      nbytes = 1;
    end
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[bi + 12'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic report(input string field, input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("ERR %0s %0s: expected %h, actual %h", test_name, field, exp_v, act_v);
    err_count = err_count + 1;
  endtask

  always @(posedge clkb) begin : compare
    lsu_pkg::rv_mem_instr_u u;
    logic [32:0] r;
    logic        exp_lv;
    logic        exp_af;
    logic        exp_st;
    logic        next_fault;
    if (rstb) begin
      err_count   = 0;
      exp_fault_q = 1'b0;
      stall_q     = 1'b0;
    end else begin
      u          = instr;
      exp_lv     = 1'b0;
      exp_af     = exp_fault_q;
      next_fault = 1'b0;
      // a new load stalls once, its held copy does not
      exp_st     = instr_valid && (u.i_fmt.opcode == lsu_pkg::OPC_LOAD) && !stall_q;
      if (stall != exp_st) begin
        report("stall", 32'(exp_st), 32'(stall));
      end
      if (instr_valid && !stall) begin
        r = ref_access(instr, rs1_val);
        if (u.i_fmt.opcode == lsu_pkg::OPC_LOAD) begin
          exp_lv = !r[32];
          exp_af = exp_af | r[32];
          if (exp_lv && load_rd != u.i_fmt.rd) begin
            report("load_rd", 32'(u.i_fmt.rd), 32'(load_rd));
          end
          if (exp_lv && load_data != r[31:0]) begin
            report("load_data", r[31:0], load_data);
          end
        end else if (u.s_fmt.opcode == lsu_pkg::OPC_STORE) begin
          next_fault = r[32];
          if (!r[32]) begin
            store_ref(instr, rs1_val, rs2_val);
          end
        end
      end
      if (load_valid != exp_lv) begin
        report("load_valid", 32'(exp_lv), 32'(load_valid));
      end
      if (access_fault != exp_af) begin
        report("access_fault", 32'(exp_af), 32'(access_fault));
      end
      exp_fault_q = next_fault;
      stall_q     = exp_st && stall;
    end
  end

endmodule

`default_nettype wire

//--- sim/lsu_tb.sv
// load/store unit testbench
`default_nettype none

module lsu_tb;

  // instruction counts of the six tests
  localparam int TOTAL_INSTR = 8 + 8 + 25 + 12 + 12 + 300;
  localparam int CYCLE_LIMIT = 3 * TOTAL_INSTR + 100;

  logic        clkb;
  logic        rstb;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        stall;
  logic        load_valid;
  logic [4:0]  load_rd;
  logic [31:0] load_data;
  logic        access_fault;
  string       test_name;
  int          check_errs;
  int          errs_before;
  int          local_errs;
  int          tests_ok;
  int          tests_bad;
  int          cycles;
  integer      seed;

  lsu_top dut_i (
    .clkb         (clkb),
    .rstb         (rstb),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .stall        (stall),
    .load_valid   (load_valid),
    .load_rd      (load_rd),
    .load_data    (load_data),
    .access_fault (access_fault)
  );

  lsu_checker chk_i (
    .clkb         (clkb),
    .rstb         (rstb),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .stall        (stall),
    .load_valid   (load_valid),
    .load_rd      (load_rd),
    .load_data    (load_data),
    .access_fault (access_fault),
    .test_name    (test_name),
    .err_count    (check_errs)
  );

  initial begin
    clkb = 1'b0;
    forever #20 clkb = ~clkb;
  end

  always @(posedge clkb) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // rs1 is x1, rs2 is x2 in every word
  function automatic logic [31:0] load_word(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [11:0] imm);
    return {imm, 5'd1, f3, rd, lsu_pkg::OPC_LOAD};
  endfunction

  function automatic logic [31:0] store_word(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], lsu_pkg::OPC_STORE};
  endfunction

  task automatic issue_instr(input logic [31:0] w, input logic [31:0] a, input logic [31:0] d);
    @(negedge clkb);
    instr_valid = 1'b1;
    instr       = w;
    rs1_val     = a;
    rs2_val     = d;
    // hold until accepted
    do @(posedge clkb); while (stall);
  endtask

  task automatic load_op(input logic [2:0] f3, input logic [4:0] rd, input logic [31:0] off);
    issue_instr(load_word(f3, rd, 12'h000), lsu_pkg::DMEM_BASE + off, 32'h0);
  endtask

  task automatic store_op(input logic [2:0] f3, input logic [31:0] off, input logic [31:0] d);
    issue_instr(store_word(f3, 12'h000), lsu_pkg::DMEM_BASE + off, d);
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clkb);
    instr_valid = 1'b0;
    repeat (n) @(posedge clkb);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    errs_before = check_errs + local_errs;
  endtask

  task automatic finish_test();
    idle_cycles(3);
    // the checker has settled the last edge by now
    @(negedge clkb);
    if (check_errs + local_errs == errs_before) begin
      tests_ok = tests_ok + 1;
      $display("test %0s: ok", test_name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %0s: %0d errors", test_name, check_errs + local_errs - errs_before);
    end
  endtask

  initial begin
    logic [2:0]  f3;
    logic [31:0] off;
    logic [3:0]  imm4;
    instr_valid = 1'b0;
    instr       = 32'h0;
    rs1_val     = 32'h0;
    rs2_val     = 32'h0;
    rstb        = 1'b1;
    seed        = 32'h1ed8;
    local_errs  = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    cycles      = 0;

    start_test("reset_zero");
    // good and faulty loads presented during reset leave no response
    for (int i = 0; i < 4; i++) begin
      @(negedge clkb);
      if (load_valid || access_fault) begin
        $display("during reset, load_valid or access_fault is not low");
        local_errs = local_errs + 1;
      end
      instr_valid = 1'b1;
      instr       = load_word(lsu_pkg::F3_W, 5'd1, 12'h000);
      rs1_val     = lsu_pkg::DMEM_BASE + ((i < 2) ? 32'h0 : 32'h1000);
    end
    @(negedge clkb);
    if (load_valid || access_fault) begin
      $display("after reset, load_valid or access_fault is not low");
      local_errs = local_errs + 1;
    end
    instr_valid = 1'b0;
    rstb        = 1'b0;
    for (int i = 0; i < 8; i++) begin
      load_op(lsu_pkg::F3_W, 5'(i + 1), 32'(i * 512 + 4 * i));
    end
    finish_test();

    start_test("sw_lw");
    store_op(lsu_pkg::F3_W, 32'd0, 32'h1234_5678);
    load_op(lsu_pkg::F3_W, 5'd3, 32'd0);
    store_op(lsu_pkg::F3_W, 32'd20, 32'hdead_beef);
    store_op(lsu_pkg::F3_W, 32'd36, 32'hcafe_f00d);
    load_op(lsu_pkg::F3_W, 5'd4, 32'd36);
    load_op(lsu_pkg::F3_W, 5'd5, 32'd20);
    store_op(lsu_pkg::F3_W, 32'hffc, 32'h8000_0001);
    load_op(lsu_pkg::F3_W, 5'd6, 32'hffc);
    finish_test();

    start_test("sub_word");
    store_op(lsu_pkg::F3_W, 32'd64, 32'h0);
    for (int o = 0; o < 4; o++) begin
      store_op(lsu_pkg::F3_B, 32'(64 + o), 32'h70 + 32'(o * 16));
    end
    for (int o = 0; o < 4; o++) begin
      load_op(lsu_pkg::F3_B, 5'(o + 8), 32'(64 + o));
      load_op(lsu_pkg::F3_BU, 5'(o + 12), 32'(64 + o));
    end
    for (int o = 0; o < 4; o += 2) begin
      load_op(lsu_pkg::F3_H, 5'd16, 32'(64 + o));
      load_op(lsu_pkg::F3_HU, 5'd17, 32'(64 + o));
    end
    load_op(lsu_pkg::F3_W, 5'd18, 32'd64);
    store_op(lsu_pkg::F3_H, 32'd68, 32'hffff_8001);
    store_op(lsu_pkg::F3_H, 32'd70, 32'h0000_7ffe);
    load_op(lsu_pkg::F3_H, 5'd19, 32'd68);
    load_op(lsu_pkg::F3_HU, 5'd20, 32'd68);
    load_op(lsu_pkg::F3_H, 5'd21, 32'd70);
    load_op(lsu_pkg::F3_HU, 5'd22, 32'd70);
    load_op(lsu_pkg::F3_W, 5'd23, 32'd68);
    finish_test();

    start_test("faults");
    store_op(lsu_pkg::F3_W, 32'd80, 32'h0bad_cafe);
    load_op(lsu_pkg::F3_H, 5'd7, 32'd81);
    load_op(lsu_pkg::F3_W, 5'd8, 32'd82);
    store_op(lsu_pkg::F3_W, 32'd81, 32'h1);
    store_op(lsu_pkg::F3_H, 32'd83, 32'h2);
    issue_instr(load_word(lsu_pkg::F3_W, 5'd9, 12'hffc), lsu_pkg::DMEM_BASE, 32'h0);
    store_op(lsu_pkg::F3_W, 32'h1000, 32'h3);
    load_op(lsu_pkg::F3_W, 5'd10, 32'h1000);
    load_op(3'b011, 5'd11, 32'd80);
    store_op(lsu_pkg::F3_BU, 32'd80, 32'h4);
    load_op(3'b110, 5'd11, 32'd80);
    load_op(lsu_pkg::F3_W, 5'd12, 32'd80);
    finish_test();

    start_test("stall_overlap");
    load_op(lsu_pkg::F3_W, 5'd1, 32'd0);
    load_op(lsu_pkg::F3_B, 5'd2, 32'd64);
    load_op(lsu_pkg::F3_HU, 5'd3, 32'd68);
    load_op(lsu_pkg::F3_W, 5'd4, 32'd20);
    store_op(lsu_pkg::F3_W, 32'd100, 32'h1122_3344);
    load_op(lsu_pkg::F3_W, 5'd5, 32'd100);
    store_op(lsu_pkg::F3_B, 32'd101, 32'h0000_00a5);
    load_op(lsu_pkg::F3_W, 5'd6, 32'd100);
    store_op(lsu_pkg::F3_H, 32'd102, 32'h0000_9abc);
    load_op(lsu_pkg::F3_W, 5'd7, 32'd100);
    // addi and add words, not memory ops
    issue_instr(32'h0000_0013, lsu_pkg::DMEM_BASE, 32'h0);
    issue_instr(32'h0020_80b3, lsu_pkg::DMEM_BASE, 32'h0);
    finish_test();

    start_test("random");
    for (int n = 0; n < 300; n++) begin
      f3   = 3'($random(seed));
      off  = 32'($random(seed)) & 32'h0000_0fff;
      imm4 = 4'($random(seed));
      // an occasional access past the top of the window
      if ((32'($random(seed)) & 32'hf) == 32'h0) begin
        off = off + 32'h0000_1000;
      end
      if ((32'($random(seed)) & 32'h1) == 32'h1) begin
        issue_instr(store_word(f3, {{8{imm4[3]}}, imm4}), lsu_pkg::DMEM_BASE + off,
                    32'($random(seed)));
      end else begin
        issue_instr(load_word(f3, 5'($random(seed)), {{8{imm4[3]}}, imm4}),
                    lsu_pkg::DMEM_BASE + off, 32'h0);
      end
    end
    finish_test();

    $display("tests: %0d passed, %0d failed", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/lsu_pkg.sv
verilog/lsu_ctrl.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/data_bram.sv
verilog/lsu_top.sv
sim/lsu_assertions.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- Makefile
# Verilator build and run for the load/store unit

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
